// ==== logic/mmu_rx_pkg.sv ====
package mmu_rx_pkg;

   // ----------------------------------------
   // widths and sizes
   // ----------------------------------------
   localparam int DATA_W    = 512;
   localparam int KEEP_W    = 64;
   localparam int ADDR_W    = 64;
   localparam int ID_W      = 4;
   localparam int LEN_W     = 8;
   localparam int CMD_DEPTH = 4;
   localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
   localparam int CPU_A_W   = 24;
   localparam int CPU_D_W   = 32;

   // arsize code for full 64-byte beats
   localparam logic [2:0] SIZE_64B = 3'd6;

   // ----------------------------------------
   // register map
   // ----------------------------------------
   localparam logic [CPU_D_W-1:0] REG_MMU_RX_ID = 32'h0000_0a5c;

   localparam logic [CPU_A_W-1:0] ADDR_ID      = 24'h00_0000;
   localparam logic [CPU_A_W-1:0] ADDR_CFG     = 24'h00_0004;
   localparam logic [CPU_A_W-1:0] ADDR_BD_CNT  = 24'h00_0008;
   localparam logic [CPU_A_W-1:0] ADDR_PKT_CNT = 24'h00_000c;
   localparam logic [CPU_A_W-1:0] ADDR_ERR_CNT = 24'h00_0010;

   // ----------------------------------------
   // types
   // ----------------------------------------
   typedef enum logic [3:0] {
      BD_OP_NOP  = 4'd0,
      BD_OP_READ = 4'd1
   } bd_op_e;

   // low 80 bits of a kernel BD beat, op in the top nibble
   typedef struct packed {
      bd_op_e              op;
      logic [ID_W-1:0]     chn;
      logic [LEN_W-1:0]    beats;
      logic [ADDR_W-1:0]   ddr_addr;
   } bd_t;

   // len is already beats minus one
   typedef struct packed {
      logic [ID_W-1:0]     id;
      logic [ADDR_W-1:0]   addr;
      logic [LEN_W-1:0]    len;
   } rd_cmd_t;

   typedef enum logic [1:0] {
      ADP_IDLE,
      ADP_ADDR,
      ADP_DATA
   } adp_state_e;

   typedef struct packed {
      logic bd_acc;
      logic bd_err;
      logic pkt_done;
   } rx_stat_t;

endpackage

// ==== logic/mmu_rx_bd.sv ====
`timescale 1ns/1ps

module mmu_rx_bd (
   input  logic                            clk_sys,
   input  logic                            rst_n,

   // kernel BD stream
   input  logic [mmu_rx_pkg::DATA_W-1:0]   ker2mmu_bd_tdata,
   input  logic [mmu_rx_pkg::KEEP_W-1:0]   ker2mmu_bd_tkeep,
   input  logic                            ker2mmu_bd_tlast,
   input  logic                            ker2mmu_bd_tvalid,
   output logic                            mmu2ker_bd_tready,

   input  logic                            rxbd_en,

   // read command queue
   input  logic                            rcmd_full,
   output logic                            rcmd_wen,
   output mmu_rx_pkg::rd_cmd_t             rcmd_wdata,

   // statistic pulses
   output logic                            bd_acc,
   output logic                            bd_err
);

   mmu_rx_pkg::bd_t bd;
   logic            bd_accept;
   logic            bd_keep_ok;
   logic            bd_good;
   logic            first_beat;

   assign mmu2ker_bd_tready = rxbd_en & ~rcmd_full;
   assign bd_accept         = ker2mmu_bd_tvalid & mmu2ker_bd_tready;

   assign bd = mmu_rx_pkg::bd_t'(ker2mmu_bd_tdata[$bits(mmu_rx_pkg::bd_t)-1:0]);

   // every byte of the BD field must be present
   assign bd_keep_ok = &ker2mmu_bd_tkeep[$bits(mmu_rx_pkg::bd_t)/8-1:0];

   // a good BD is a single beat read with a nonzero length
   assign bd_good = (bd.op == mmu_rx_pkg::BD_OP_READ) &&
                    (bd.beats != '0) &&
                    ker2mmu_bd_tlast &&
                    bd_keep_ok;

   // ----------------------------------------
   // beat tracking
   // ----------------------------------------
   // beats after a first beat without tlast are dropped
   always_ff @(posedge clk_sys) begin
      if (!rst_n) begin
         first_beat <= 1'b1;
      end else if (bd_accept) begin
         first_beat <= ker2mmu_bd_tlast;
      end
   end

   assign rcmd_wen = bd_accept & first_beat & bd_good;
   assign bd_acc   = rcmd_wen;
   assign bd_err   = bd_accept & first_beat & ~bd_good;

   // chn becomes the AXI id
   always_comb begin
      rcmd_wdata.id   = bd.chn;
      rcmd_wdata.addr = bd.ddr_addr;
      rcmd_wdata.len  = bd.beats - 1'b1;
   end

endmodule

// ==== logic/axi4m_rd_adp.sv ====
`timescale 1ns/1ps

module axi4m_rd_adp (
   input  logic                            clk_sys,
   input  logic                            rst_n,

   // command queue write side
   input  logic                            rcmd_wen,
   input  mmu_rx_pkg::rd_cmd_t             rcmd_wdata,
   output logic                            rcmd_full,

   // AXI4 read address
   output logic [mmu_rx_pkg::ID_W-1:0]     axi4m_ddr_arid,
   output logic [mmu_rx_pkg::ADDR_W-1:0]   axi4m_ddr_araddr,
   output logic [mmu_rx_pkg::LEN_W-1:0]    axi4m_ddr_arlen,
   output logic [2:0]                      axi4m_ddr_arsize,
   output logic                            axi4m_ddr_arvalid,
   input  logic                            axi4m_ddr_arready,

   // AXI4 read data, monitored only
   input  logic                            axi4m_ddr_rlast,
   input  logic                            axi4m_ddr_rvalid,
   input  logic                            axi4m_ddr_rready
);

   mmu_rx_pkg::rd_cmd_t             cmd_mem [mmu_rx_pkg::CMD_DEPTH];
   logic [mmu_rx_pkg::CMD_PTR_W-1:0] wr_ptr;
   logic [mmu_rx_pkg::CMD_PTR_W-1:0] rd_ptr;
   logic [mmu_rx_pkg::CMD_PTR_W:0]   cmd_cnt;
   logic                            cmd_empty;
   logic                            cmd_push;
   logic                            cmd_pop;
   logic                            take_direct;
   logic                            burst_done;
   mmu_rx_pkg::adp_state_e          state;
   mmu_rx_pkg::rd_cmd_t             cur_cmd;

   // ----------------------------------------
   // command FIFO
   // ----------------------------------------
   assign cmd_empty = (cmd_cnt == '0);
   assign rcmd_full = (cmd_cnt == (mmu_rx_pkg::CMD_PTR_W+1)'(mmu_rx_pkg::CMD_DEPTH));

   // an idle adapter with an empty queue takes the command straight in
   assign take_direct = (state == mmu_rx_pkg::ADP_IDLE) & cmd_empty & rcmd_wen;
   assign cmd_push    = rcmd_wen & ~take_direct;
   assign cmd_pop     = (state == mmu_rx_pkg::ADP_IDLE) & ~cmd_empty;

   always_ff @(posedge clk_sys) begin
      if (cmd_push) begin
         cmd_mem[wr_ptr] <= rcmd_wdata;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         cmd_cnt <= '0;
      end else begin
         if (cmd_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (cmd_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (cmd_push && !cmd_pop) begin
            cmd_cnt <= cmd_cnt + 1'b1;
         end else if (cmd_pop && !cmd_push) begin
            cmd_cnt <= cmd_cnt - 1'b1;
         end
      end
   end

   // ----------------------------------------
   // burst issue FSM
   // ----------------------------------------
   assign burst_done = axi4m_ddr_rvalid & axi4m_ddr_rready & axi4m_ddr_rlast;

   always_ff @(posedge clk_sys) begin
      if (!rst_n) begin
         state <= mmu_rx_pkg::ADP_IDLE;
      end else begin
         case (state)
            mmu_rx_pkg::ADP_IDLE: begin
               if (cmd_pop || take_direct) begin
                  state <= mmu_rx_pkg::ADP_ADDR;
               end
            end
            mmu_rx_pkg::ADP_ADDR: begin
               if (axi4m_ddr_arready) begin
                  state <= mmu_rx_pkg::ADP_DATA;
               end
            end
            mmu_rx_pkg::ADP_DATA: begin
               // one burst in flight at a time
               if (burst_done) begin
                  state <= mmu_rx_pkg::ADP_IDLE;
               end
            end
            default: state <= mmu_rx_pkg::ADP_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_sys) begin
      if (cmd_pop) begin
         cur_cmd <= cmd_mem[rd_ptr];
      end else if (take_direct) begin
         cur_cmd <= rcmd_wdata;
      end
   end

   assign axi4m_ddr_arvalid = (state == mmu_rx_pkg::ADP_ADDR);
   assign axi4m_ddr_arid    = cur_cmd.id;
   assign axi4m_ddr_araddr  = cur_cmd.addr;
   assign axi4m_ddr_arlen   = cur_cmd.len;
   assign axi4m_ddr_arsize  = mmu_rx_pkg::SIZE_64B;

endmodule

// ==== logic/mmu_rx_pkt.sv ====
`timescale 1ns/1ps

module mmu_rx_pkt (
   input  logic                            clk_sys,
   input  logic                            rst_n,

   // AXI4 read data from DDR
   input  logic [mmu_rx_pkg::DATA_W-1:0]   axi4m_ddr_rdata,
   input  logic                            axi4m_ddr_rlast,
   input  logic                            axi4m_ddr_rvalid,
   output logic                            axi4m_ddr_rready,

   // packet stream toward the shell
   output logic [mmu_rx_pkg::DATA_W-1:0]   ul2sh_pkt_tdata,
   output logic [mmu_rx_pkg::KEEP_W-1:0]   ul2sh_pkt_tkeep,
   output logic                            ul2sh_pkt_tlast,
   output logic                            ul2sh_pkt_tvalid,
   input  logic                            sh2ul_pkt_tready,

   output logic                            pkt_done
);

   typedef struct packed {
      logic                          last;
      logic [mmu_rx_pkg::DATA_W-1:0] data;
   } beat_t;

   beat_t      buf_mem [2];
   logic       wr_sel;
   logic       rd_sel;
   logic [1:0] fill;
   logic       in_push;
   logic       out_pop;

   assign axi4m_ddr_rready = (fill != 2'd2);
   assign ul2sh_pkt_tvalid = (fill != 2'd0);

   assign in_push = axi4m_ddr_rvalid & axi4m_ddr_rready;
   assign out_pop = ul2sh_pkt_tvalid & sh2ul_pkt_tready;

   always_ff @(posedge clk_sys) begin
      if (in_push) begin
         buf_mem[wr_sel] <= '{last: axi4m_ddr_rlast, data: axi4m_ddr_rdata};
      end
   end

   always_ff @(posedge clk_sys) begin
      if (!rst_n) begin
         wr_sel <= 1'b0;
         rd_sel <= 1'b0;
         fill   <= 2'd0;
      end else begin
         if (in_push) begin
            wr_sel <= ~wr_sel;
         end
         if (out_pop) begin
            rd_sel <= ~rd_sel;
         end
         if (in_push && !out_pop) begin
            fill <= fill + 2'd1;
         end else if (out_pop && !in_push) begin
            fill <= fill - 2'd1;
         end
      end
   end

   assign ul2sh_pkt_tdata = buf_mem[rd_sel].data;
   assign ul2sh_pkt_tlast = buf_mem[rd_sel].last;
   assign ul2sh_pkt_tkeep = '1;

   // end of packet leaves on this cycle
   assign pkt_done = out_pop & ul2sh_pkt_tlast;

endmodule

// ==== logic/reg_mmu_rx.sv ====
`timescale 1ns/1ps

module reg_mmu_rx (
   input  logic                             clk_sys,
   input  logic                             rst_n,

   // CPU access
   input  logic [mmu_rx_pkg::CPU_A_W-1:0]   cpu_addr,
   input  logic [mmu_rx_pkg::CPU_D_W-1:0]   cpu_data_in,
   input  logic                             cpu_wr,
   input  logic                             cpu_rd,
   output logic [mmu_rx_pkg::CPU_D_W-1:0]   cpu_data_out_vf,

   input  logic                             cnt_reg_clr,
   input  mmu_rx_pkg::rx_stat_t             stat,
   output logic                             rxbd_en
);

   logic [mmu_rx_pkg::CPU_D_W-1:0] cfg_reg;
   logic [mmu_rx_pkg::CPU_D_W-1:0] stat_cnt [3];
   logic [2:0]                     stat_evt;
   logic [mmu_rx_pkg::CPU_D_W-1:0] rd_mux;

   // ----------------------------------------
   // config
   // ----------------------------------------
   always_ff @(posedge clk_sys) begin
      if (!rst_n) begin
         cfg_reg <= '0;
      end else if (cpu_wr && (cpu_addr == mmu_rx_pkg::ADDR_CFG)) begin
         cfg_reg <= cpu_data_in;
      end
   end

   assign rxbd_en = cfg_reg[0];

   // ----------------------------------------
   // statistic counters
   // ----------------------------------------
   // index 0 BDs accepted, 1 packets sent, 2 BDs rejected
   assign stat_evt = {stat.bd_err, stat.pkt_done, stat.bd_acc};

   always_ff @(posedge clk_sys) begin
      if (!rst_n || cnt_reg_clr) begin
         for (int i = 0; i < 3; i++) begin
            stat_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (stat_evt[i]) begin
               stat_cnt[i] <= stat_cnt[i] + 1'b1;
            end
         end
      end
   end

   // ----------------------------------------
   // read back
   // ----------------------------------------
   always_comb begin
      case (cpu_addr)
         mmu_rx_pkg::ADDR_ID:      rd_mux = mmu_rx_pkg::REG_MMU_RX_ID;
         mmu_rx_pkg::ADDR_CFG:     rd_mux = cfg_reg;
         mmu_rx_pkg::ADDR_BD_CNT:  rd_mux = stat_cnt[0];
         mmu_rx_pkg::ADDR_PKT_CNT: rd_mux = stat_cnt[1];
         mmu_rx_pkg::ADDR_ERR_CNT: rd_mux = stat_cnt[2];
         default:                  rd_mux = '0;
      endcase
   end

   // value stays until the next read
   always_ff @(posedge clk_sys) begin
      if (!rst_n) begin
         cpu_data_out_vf <= '0;
      end else if (cpu_rd) begin
         cpu_data_out_vf <= rd_mux;
      end
   end

endmodule

// ==== logic/mmu_rx_top.sv ====
`timescale 1ns/1ps

module mmu_rx_top (
   input  logic                             clk_sys,
   input  logic                             rst_n,

   // kernel BD stream
   input  logic [mmu_rx_pkg::DATA_W-1:0]    ker2mmu_bd_tdata,
   input  logic [mmu_rx_pkg::KEEP_W-1:0]    ker2mmu_bd_tkeep,
   input  logic                             ker2mmu_bd_tlast,
   input  logic                             ker2mmu_bd_tvalid,
   output logic                             mmu2ker_bd_tready,

   // AXI4 read address to DDR
   output logic [mmu_rx_pkg::ID_W-1:0]      axi4m_ddr_arid,
   output logic [mmu_rx_pkg::ADDR_W-1:0]    axi4m_ddr_araddr,
   output logic [mmu_rx_pkg::LEN_W-1:0]     axi4m_ddr_arlen,
   output logic [2:0]                       axi4m_ddr_arsize,
   output logic                             axi4m_ddr_arvalid,
   input  logic                             axi4m_ddr_arready,

   // AXI4 read data from DDR
   input  logic [mmu_rx_pkg::DATA_W-1:0]    axi4m_ddr_rdata,
   input  logic                             axi4m_ddr_rlast,
   input  logic                             axi4m_ddr_rvalid,
   output logic                             axi4m_ddr_rready,

   // packet stream toward the shell
   output logic [mmu_rx_pkg::DATA_W-1:0]    ul2sh_pkt_tdata,
   output logic [mmu_rx_pkg::KEEP_W-1:0]    ul2sh_pkt_tkeep,
   output logic                             ul2sh_pkt_tlast,
   output logic                             ul2sh_pkt_tvalid,
   input  logic                             sh2ul_pkt_tready,

   // CPU
   input  logic                             cnt_reg_clr,
   input  logic [mmu_rx_pkg::CPU_A_W-1:0]   cpu_addr,
   input  logic [mmu_rx_pkg::CPU_D_W-1:0]   cpu_data_in,
   output logic [mmu_rx_pkg::CPU_D_W-1:0]   cpu_data_out_vf,
   input  logic                             cpu_rd,
   input  logic                             cpu_wr
);

   logic                 rxbd_en;
   logic                 rcmd_full;
   logic                 rcmd_wen;
   mmu_rx_pkg::rd_cmd_t  rcmd_wdata;
   logic                 bd_acc;
   logic                 bd_err;
   logic                 pkt_done;
   mmu_rx_pkg::rx_stat_t stat;

   assign stat = '{bd_acc: bd_acc, bd_err: bd_err, pkt_done: pkt_done};

   mmu_rx_bd u_mmu_rx_bd (
      .clk_sys           (clk_sys),
      .rst_n             (rst_n),
      .ker2mmu_bd_tdata  (ker2mmu_bd_tdata),
      .ker2mmu_bd_tkeep  (ker2mmu_bd_tkeep),
      .ker2mmu_bd_tlast  (ker2mmu_bd_tlast),
      .ker2mmu_bd_tvalid (ker2mmu_bd_tvalid),
      .mmu2ker_bd_tready (mmu2ker_bd_tready),
      .rxbd_en           (rxbd_en),
      .rcmd_full         (rcmd_full),
      .rcmd_wen          (rcmd_wen),
      .rcmd_wdata        (rcmd_wdata),
      .bd_acc            (bd_acc),
      .bd_err            (bd_err)
   );

   axi4m_rd_adp u_axi4m_rd_adp (
      .clk_sys           (clk_sys),
      .rst_n             (rst_n),
      .rcmd_wen          (rcmd_wen),
      .rcmd_wdata        (rcmd_wdata),
      .rcmd_full         (rcmd_full),
      .axi4m_ddr_arid    (axi4m_ddr_arid),
      .axi4m_ddr_araddr  (axi4m_ddr_araddr),
      .axi4m_ddr_arlen   (axi4m_ddr_arlen),
      .axi4m_ddr_arsize  (axi4m_ddr_arsize),
      .axi4m_ddr_arvalid (axi4m_ddr_arvalid),
      .axi4m_ddr_arready (axi4m_ddr_arready),
      .axi4m_ddr_rlast   (axi4m_ddr_rlast),
      .axi4m_ddr_rvalid  (axi4m_ddr_rvalid),
      .axi4m_ddr_rready  (axi4m_ddr_rready)
   );

   mmu_rx_pkt u_mmu_rx_pkt (
      .clk_sys           (clk_sys),
      .rst_n             (rst_n),
      .axi4m_ddr_rdata   (axi4m_ddr_rdata),
      .axi4m_ddr_rlast   (axi4m_ddr_rlast),
      .axi4m_ddr_rvalid  (axi4m_ddr_rvalid),
      .axi4m_ddr_rready  (axi4m_ddr_rready),
      .ul2sh_pkt_tdata   (ul2sh_pkt_tdata),
      .ul2sh_pkt_tkeep   (ul2sh_pkt_tkeep),
      .ul2sh_pkt_tlast   (ul2sh_pkt_tlast),
      .ul2sh_pkt_tvalid  (ul2sh_pkt_tvalid),
      .sh2ul_pkt_tready  (sh2ul_pkt_tready),
      .pkt_done          (pkt_done)
   );

   reg_mmu_rx u_reg_mmu_rx (
      .clk_sys           (clk_sys),
      .rst_n             (rst_n),
      .cpu_addr          (cpu_addr),
      .cpu_data_in       (cpu_data_in),
      .cpu_wr            (cpu_wr),
      .cpu_rd            (cpu_rd),
      .cpu_data_out_vf   (cpu_data_out_vf),
      .cnt_reg_clr       (cnt_reg_clr),
      .stat              (stat),
      .rxbd_en           (rxbd_en)
   );

endmodule

// ==== dv/ddr_rd_model.sv ====
`timescale 1ns/1ps

module ddr_rd_model (
   input  logic                            clk_sys,
   input  logic                            rst_n,

   // read address
   input  logic [mmu_rx_pkg::ADDR_W-1:0]   araddr,
   input  logic [mmu_rx_pkg::LEN_W-1:0]    arlen,
   input  logic                            arvalid,
   output logic                            arready,

   // read data
   output logic [mmu_rx_pkg::DATA_W-1:0]   rdata,
   output logic                            rlast,
   output logic                            rvalid,
   input  logic                            rready
);

   logic [mmu_rx_pkg::ADDR_W-1:0] ar_addr;
   logic [mmu_rx_pkg::LEN_W-1:0]  ar_len;

   // one burst at a time, as the master never has two in flight
   initial begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rdata   <= '0;
      forever begin
         @(posedge clk_sys);
         if (rst_n && arvalid) begin
            ar_addr = araddr;
            ar_len  = arlen;
            arready <= 1'b1;
            @(posedge clk_sys);
            arready <= 1'b0;
            // latency varies a little with the address
            repeat (2 + int'(ar_addr[7:6])) @(posedge clk_sys);
            for (int k = 0; k <= int'(ar_len); k++) begin
               rvalid <= 1'b1;
               rdata  <= {16{ar_addr[31:0] + 32'(k * 64)}};
               rlast  <= (k == int'(ar_len));
               do begin
                  @(posedge clk_sys);
               end while (!rready);
            end
            rvalid <= 1'b0;
            rlast  <= 1'b0;
         end
      end
   end

endmodule

// ==== dv/mmu_rx_tb.sv ====
`timescale 1ns/1ps

module mmu_rx_tb;

   // one line of the pattern file
   typedef struct packed {
      mmu_rx_pkg::bd_t bd;
      logic            stall;
      logic [31:0]     bd_cnt;
      logic [31:0]     pkt_cnt;
      logic [31:0]     err_cnt;
   } test_vec_t;

   logic                             clk_sys;
   logic                             rst_n;
   logic [mmu_rx_pkg::DATA_W-1:0]    ker2mmu_bd_tdata;
   logic [mmu_rx_pkg::KEEP_W-1:0]    ker2mmu_bd_tkeep;
   logic                             ker2mmu_bd_tlast;
   logic                             ker2mmu_bd_tvalid;
   logic                             mmu2ker_bd_tready;
   logic [mmu_rx_pkg::ID_W-1:0]      axi4m_ddr_arid;
   logic [mmu_rx_pkg::ADDR_W-1:0]    axi4m_ddr_araddr;
   logic [mmu_rx_pkg::LEN_W-1:0]     axi4m_ddr_arlen;
   logic [2:0]                       axi4m_ddr_arsize;
   logic                             axi4m_ddr_arvalid;
   logic                             axi4m_ddr_arready;
   logic [mmu_rx_pkg::DATA_W-1:0]    axi4m_ddr_rdata;
   logic                             axi4m_ddr_rlast;
   logic                             axi4m_ddr_rvalid;
   logic                             axi4m_ddr_rready;
   logic [mmu_rx_pkg::DATA_W-1:0]    ul2sh_pkt_tdata;
   logic [mmu_rx_pkg::KEEP_W-1:0]    ul2sh_pkt_tkeep;
   logic                             ul2sh_pkt_tlast;
   logic                             ul2sh_pkt_tvalid;
   logic                             sh2ul_pkt_tready;
   logic                             cnt_reg_clr;
   logic [mmu_rx_pkg::CPU_A_W-1:0]   cpu_addr;
   logic [mmu_rx_pkg::CPU_D_W-1:0]   cpu_data_in;
   logic [mmu_rx_pkg::CPU_D_W-1:0]   cpu_data_out_vf;
   logic                             cpu_rd;
   logic                             cpu_wr;

   test_vec_t                        tests [$];
   mmu_rx_pkg::rd_cmd_t              exp_ar [$];
   logic [mmu_rx_pkg::DATA_W-1:0]    exp_data [$];
   logic                             exp_last [$];
   mmu_rx_pkg::rd_cmd_t              act_ar;
   int                               ar_idx;
   int                               beat_idx;
   int                               main_errs;
   int                               mon_errs;
   int                               wd_cycles;
   logic                             stall_on;
   logic [15:0]                      lfsr;

   mmu_rx_top mmu_rx_top_inst (.*);

   ddr_rd_model u_ddr (
      .clk_sys (clk_sys),
      .rst_n   (rst_n),
      .araddr  (axi4m_ddr_araddr),
      .arlen   (axi4m_ddr_arlen),
      .arvalid (axi4m_ddr_arvalid),
      .arready (axi4m_ddr_arready),
      .rdata   (axi4m_ddr_rdata),
      .rlast   (axi4m_ddr_rlast),
      .rvalid  (axi4m_ddr_rvalid),
      .rready  (axi4m_ddr_rready)
   );

   initial begin
      clk_sys = 1'b0;
      forever #20 clk_sys = ~clk_sys;
   end

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic check_ar(input mmu_rx_pkg::rd_cmd_t exp, input mmu_rx_pkg::rd_cmd_t act,
                           input logic [2:0] size, inout int errs);
      if (act.id !== exp.id) begin
         errs++;
         $display("Error axi4m_ddr_arid expected %h actual %h", exp.id, act.id);
      end
      if (act.addr !== exp.addr) begin
         errs++;
         $display("Error axi4m_ddr_araddr expected %h actual %h", exp.addr, act.addr);
      end
      if (act.len !== exp.len) begin
         errs++;
         $display("Error axi4m_ddr_arlen expected %h actual %h", exp.len, act.len);
      end
      if (size !== mmu_rx_pkg::SIZE_64B) begin
         errs++;
         $display("Error axi4m_ddr_arsize expected %h actual %h", mmu_rx_pkg::SIZE_64B, size);
      end
   endtask

   task automatic check_beat(input logic [mmu_rx_pkg::DATA_W-1:0] exp_d, input logic exp_l,
                             input logic [mmu_rx_pkg::DATA_W-1:0] act_d, input logic act_l,
                             input logic [mmu_rx_pkg::KEEP_W-1:0] act_k, inout int errs);
      if (act_d !== exp_d) begin
         errs++;
         $display("Error ul2sh_pkt_tdata expected %h actual %h", exp_d, act_d);
      end
      if (act_l !== exp_l) begin
         errs++;
         $display("Error ul2sh_pkt_tlast expected %h actual %h", exp_l, act_l);
      end
      if (act_k !== '1) begin
         errs++;
         $display("Error ul2sh_pkt_tkeep expected all ones actual %h", act_k);
      end
   endtask

   task automatic check_reg(input string name, input logic [mmu_rx_pkg::CPU_D_W-1:0] exp,
                            input logic [mmu_rx_pkg::CPU_D_W-1:0] act, inout int errs);
      if (act !== exp) begin
         errs++;
         $display("Error cpu_data_out_vf %s expected %h actual %h", name, exp, act);
      end
   endtask

   // ----------------------------------------
   // stimulus helpers
   // ----------------------------------------
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic [15:0] n;
      // galois form, taps 16 14 13 11
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hb400;
      end
      return n;
   endfunction

   task automatic load_tests();
      int        fd;
      int        n;
      int        stall;
      int        bdc;
      int        pktc;
      int        errc;
      string     line;
      logic [3:0]  op;
      logic [3:0]  chn;
      logic [7:0]  beats;
      logic [63:0] addr;
      test_vec_t tv;
      fd = $fopen("dv/mmu_rx_patterns.txt", "r");
      if (fd == 0) begin
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%h %h %h %h %d %d %d %d",
                        op, chn, beats, addr, stall, bdc, pktc, errc);
            if (n == 8) begin
               tv.bd.op       = mmu_rx_pkg::bd_op_e'(op);
               tv.bd.chn      = chn;
               tv.bd.beats    = beats;
               tv.bd.ddr_addr = addr;
               tv.stall       = (stall != 0);
               tv.bd_cnt      = bdc;
               tv.pkt_cnt     = pktc;
               tv.err_cnt     = errc;
               tests.push_back(tv);
            end
         end
      end
      $fclose(fd);
   endtask

   // expected AR and beats follow from the BD fields alone
   task automatic expect_burst(input mmu_rx_pkg::bd_t bd);
      mmu_rx_pkg::rd_cmd_t cmd;
      cmd.id   = bd.chn;
      cmd.addr = bd.ddr_addr;
      cmd.len  = bd.beats - 8'd1;
      exp_ar.push_back(cmd);
      for (int k = 0; k < int'(bd.beats); k++) begin
         exp_data.push_back({16{bd.ddr_addr[31:0] + 32'(k * 64)}});
         exp_last.push_back(k == int'(bd.beats) - 1);
      end
   endtask

   task automatic send_bd(input mmu_rx_pkg::bd_t bd);
      logic [mmu_rx_pkg::DATA_W-1:0] word;
      word = '0;
      word[$bits(mmu_rx_pkg::bd_t)-1:0] = bd;
      @(posedge clk_sys);
      ker2mmu_bd_tdata  <= word;
      ker2mmu_bd_tkeep  <= '1;
      ker2mmu_bd_tlast  <= 1'b1;
      ker2mmu_bd_tvalid <= 1'b1;
      do begin
         @(posedge clk_sys);
      end while (!mmu2ker_bd_tready);
      ker2mmu_bd_tvalid <= 1'b0;
   endtask

   task automatic cpu_write(input logic [mmu_rx_pkg::CPU_A_W-1:0] addr,
                            input logic [mmu_rx_pkg::CPU_D_W-1:0] data);
      @(posedge clk_sys);
      cpu_addr    <= addr;
      cpu_data_in <= data;
      cpu_wr      <= 1'b1;
      @(posedge clk_sys);
      cpu_wr      <= 1'b0;
   endtask

   task automatic reg_expect(input string name, input logic [mmu_rx_pkg::CPU_A_W-1:0] addr,
                             input logic [mmu_rx_pkg::CPU_D_W-1:0] exp);
      logic [mmu_rx_pkg::CPU_D_W-1:0] val;
      @(posedge clk_sys);
      cpu_addr <= addr;
      cpu_rd   <= 1'b1;
      @(posedge clk_sys);
      cpu_rd   <= 1'b0;
      @(negedge clk_sys);
      val = cpu_data_out_vf;
      check_reg(name, exp, val, main_errs);
   endtask

   task automatic count_clear();
      @(posedge clk_sys);
      cnt_reg_clr <= 1'b1;
      @(posedge clk_sys);
      cnt_reg_clr <= 1'b0;
   endtask

   task automatic report_test(input string name, input int mark, inout int failed);
      if (main_errs + mon_errs == mark) begin
         $display("test %s: pass", name);
      end else begin
         failed++;
         $display("test %s: fail", name);
      end
   endtask

   // ----------------------------------------
   // output back-pressure
   // ----------------------------------------
   initial begin
      lfsr = 16'd5969;
      sh2ul_pkt_tready <= 1'b1;
      forever begin
         @(posedge clk_sys);
         if (stall_on) begin
            lfsr = lfsr_step(lfsr);
            sh2ul_pkt_tready <= lfsr[0];
         end else begin
            sh2ul_pkt_tready <= 1'b1;
         end
      end
   end

   // monitors, sampled mid-cycle where all handshakes are stable
   always @(negedge clk_sys) begin
      if (rst_n && axi4m_ddr_arvalid && axi4m_ddr_arready) begin
         act_ar.id   = axi4m_ddr_arid;
         act_ar.addr = axi4m_ddr_araddr;
         act_ar.len  = axi4m_ddr_arlen;
         if (ar_idx >= exp_ar.size()) begin
            mon_errs++;
            $display("read request to %h with no valid BD behind it", axi4m_ddr_araddr);
         end else begin
            check_ar(exp_ar[ar_idx], act_ar, axi4m_ddr_arsize, mon_errs);
            ar_idx++;
         end
      end
      if (rst_n && ul2sh_pkt_tvalid && sh2ul_pkt_tready) begin
         if (beat_idx >= exp_data.size()) begin
            mon_errs++;
            $display("packet beat sent with no beat expected");
         end else begin
            check_beat(exp_data[beat_idx], exp_last[beat_idx], ul2sh_pkt_tdata,
                       ul2sh_pkt_tlast, ul2sh_pkt_tkeep, mon_errs);
            beat_idx++;
         end
      end
   end

   // watchdog sized from the pattern file
   initial begin
      wait (wd_cycles != 0);
      repeat (wd_cycles) @(posedge clk_sys);
      $display("timeout after %0d cycles, the DUT stopped making progress", wd_cycles);
      $display("CHECKS FAILED");
      $finish;
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      int    err_mark;
      int    total_beats;
      int    failed;
      logic  drain;
      string name;
      ker2mmu_bd_tdata  <= '0;
      ker2mmu_bd_tkeep  <= '0;
      ker2mmu_bd_tlast  <= 1'b0;
      ker2mmu_bd_tvalid <= 1'b0;
      cnt_reg_clr       <= 1'b0;
      cpu_addr          <= '0;
      cpu_data_in       <= '0;
      cpu_rd            <= 1'b0;
      cpu_wr            <= 1'b0;
      rst_n             <= 1'b0;
      stall_on = 1'b0;
      failed   = 0;
      load_tests();
      total_beats = 0;
      foreach (tests[i]) begin
         total_beats += int'(tests[i].bd.beats);
      end
      wd_cycles = total_beats * 40 + 2000;
      repeat (3) @(posedge clk_sys);
      rst_n <= 1'b1;

      if (tests.size() == 0) begin
         main_errs++;
         $display("no test vectors could be read from dv/mmu_rx_patterns.txt");
      end else begin
         err_mark = main_errs + mon_errs;
         reg_expect("ID", mmu_rx_pkg::ADDR_ID, mmu_rx_pkg::REG_MMU_RX_ID);
         reg_expect("CFG", mmu_rx_pkg::ADDR_CFG, 32'd0);
         repeat (4) begin
            @(negedge clk_sys);
            if (mmu2ker_bd_tready !== 1'b0) begin
               main_errs++;
               $display("BD tready is high while the enable bit is still clear");
            end
         end
         cpu_write(mmu_rx_pkg::ADDR_CFG, 32'd1);
         reg_expect("CFG", mmu_rx_pkg::ADDR_CFG, 32'd1);
         report_test("reset and enable", err_mark, failed);

         foreach (tests[i]) begin
            err_mark = main_errs + mon_errs;
            stall_on = tests[i].stall;
            if (tests[i].bd.op == mmu_rx_pkg::BD_OP_READ && tests[i].bd.beats != 8'd0) begin
               expect_burst(tests[i].bd);
            end
            send_bd(tests[i].bd);
            // a run of stall lines stays queued until its last line
            drain = (i == tests.size() - 1) || !tests[i].stall || !tests[i + 1].stall;
            if (drain) begin
               repeat (4) @(posedge clk_sys);
               while (beat_idx < exp_data.size() || ar_idx < exp_ar.size()) begin
                  @(posedge clk_sys);
               end
               repeat (2) @(posedge clk_sys);
               reg_expect("BD_CNT", mmu_rx_pkg::ADDR_BD_CNT, tests[i].bd_cnt);
               reg_expect("PKT_CNT", mmu_rx_pkg::ADDR_PKT_CNT, tests[i].pkt_cnt);
               reg_expect("ERR_CNT", mmu_rx_pkg::ADDR_ERR_CNT, tests[i].err_cnt);
            end
            name = $sformatf("bd %0d op %h chn %h beats %0d stall %0d", i,
                             tests[i].bd.op, tests[i].bd.chn, tests[i].bd.beats,
                             tests[i].stall);
            report_test(name, err_mark, failed);
         end
         stall_on = 1'b0;

         err_mark = main_errs + mon_errs;
         count_clear();
         reg_expect("BD_CNT", mmu_rx_pkg::ADDR_BD_CNT, 32'd0);
         reg_expect("PKT_CNT", mmu_rx_pkg::ADDR_PKT_CNT, 32'd0);
         reg_expect("ERR_CNT", mmu_rx_pkg::ADDR_ERR_CNT, 32'd0);
         report_test("counter clear", err_mark, failed);
      end

      $display("summary: %0d tests, %0d failed, %0d errors", tests.size() + 2, failed,
               main_errs + mon_errs);
      if (main_errs + mon_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== dv/mmu_rx_patterns.txt ====
# op chn beats ddr_addr (hex) stall (0/1), then BD_CNT PKT_CNT ERR_CNT as running totals
# counts are checked once the DUT drains, for a run of stall lines only at its last line
1 0 01 0000000000001000 0 1 1 0
1 3 04 0000000000002040 0 2 2 0
1 f 10 0000000180000000 0 3 3 0
2 1 04 0000000000003000 0 3 3 1
0 2 02 0000000000003100 0 3 3 2
1 7 ff 00000000deadbe00 0 4 4 2
1 1 08 0000000000010000 1 5 5 2
1 2 03 0000000000010400 1 6 6 2
1 3 01 0000000000010800 1 7 7 2
1 4 0c 0000000000010c00 1 8 8 2
1 5 05 0000000000011000 1 9 9 2
1 6 02 0000000000011400 1 10 10 2
7 0 01 0000000000012000 1 10 10 3
1 8 06 0000000000013000 1 11 11 3
1 9 02 00000002ffffffc0 0 12 12 3

// ==== build.f ====
logic/mmu_rx_pkg.sv
logic/mmu_rx_bd.sv
logic/axi4m_rd_adp.sv
logic/mmu_rx_pkt.sv
logic/reg_mmu_rx.sv
logic/mmu_rx_top.sv
dv/ddr_rd_model.sv
dv/mmu_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the mmu_rx testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --timescale 1ns/1ps --top-module mmu_rx_tb \
   -f build.f -o mmu_rx_sim > build.log 2>&1 \
   && ./obj_dir/mmu_rx_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "result: fail"; exit 1; } || { echo "result: pass"; exit 0; }
